/* vlog.f */
conv_pkg.sv
conv_counter.sv
delay_line.sv
tile_buffer.sv
conv_ctrl_path.sv
conv_mac_unit.sv
conv_apb_regs.sv
conv_tile_top.sv
tb_conv_tile.sv

/* Bender.yml */
package:
  name: conv_tile

sources:
  - conv_pkg.sv
  - conv_counter.sv
  - delay_line.sv
  - tile_buffer.sv
  - conv_ctrl_path.sv
  - conv_mac_unit.sv
  - conv_apb_regs.sv
  - conv_tile_top.sv
  - target: simulation
    files:
      - tb_conv_tile.sv

/* tb_conv_tile.sv */
// Assumes the default tile geometry and zero-wait APB; window words past 63 are reached through the paged address
`timescale 1ns/1ps

module tb_conv_tile import conv_pkg::*; ();

    localparam int k          = def_k;
    localparam int tr         = def_tr;
    localparam int tc         = def_tc;
    localparam int tm         = def_tm;
    localparam int tn         = def_tn;
    localparam int orow       = tr - k + 1;
    localparam int ocol       = tc - k + 1;
    localparam int in_depth   = tm * tr * tc;
    localparam int wt_depth   = tn * tm * k * k;
    localparam int out_depth  = tn * orow * ocol;
    localparam int ops        = tn * tm * orow * ocol * k * k;
    localparam int clk_period = 20;
    // Each APB access takes three cycles including the idle gap
    localparam int apb_cycles = 3;
    localparam int accesses   = 3 * (in_depth + wt_depth) + 2 * out_depth + 16;
    localparam int watchdog_cycles = 2 * (2 * ops + apb_cycles * accesses);

    logic              clk = 1'b0;
    logic              rst;
    logic [apb_aw-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [apb_dw-1:0] pwdata;
    logic [apb_dw-1:0] prdata;
    logic              pready;
    logic              pslverr;

    int    errors;
    int    checks;
    int    tests_passed;
    int    tests_failed;
    int    test_errors;
    int    seed_init;
    string test_name;
    // Low from an accepted start until the host sees done
    logic  host_idle;
    int    in_ref  [in_depth];
    int    wt_ref  [wt_depth];
    int    out_ref [out_depth];

    always #(clk_period / 2) clk = ~clk;

    conv_tile_top #(.k(k), .tr(tr), .tc(tc), .tm(tm), .tn(tn)) DUT (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr)
    );

    a_idle_no_err: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && host_idle) |-> !pslverr)
        else begin
            errors++;
            $display("Error in %s: slave error on an idle access to 0x%03h", test_name, paddr);
        end

    a_ready: assert property (@(posedge clk) disable iff (rst) (psel && penable) |-> pready)
        else begin
            errors++;
            $display("Error in %s: pready low in an access phase", test_name);
        end

    a_err_in_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable))
        else begin
            errors++;
            $display("Error in %s: pslverr outside an access phase", test_name);
        end

    // Word w of a window, paged every 64 words
    function automatic logic [apb_aw-1:0] win_addr(input logic [apb_aw-1:0] base, input int w);
        return base + apb_aw'((w / 64) * 'h400 + (w % 64) * 4);
    endfunction

    task automatic write_word(input logic [apb_aw-1:0] addr, input logic [apb_dw-1:0] data,
                              output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_word(input logic [apb_aw-1:0] addr, output logic [apb_dw-1:0] data,
                             output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        // Access phase, read data is settled mid-cycle
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic expect_equal(input string what, input int expected, input int actual);
        checks++;
        assert (actual == expected)
            else begin
                errors++;
                $display("FAIL %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            tests_passed++;
            $display("%-12s passed", test_name);
        end else begin
            tests_failed++;
            $display("%-12s failed with %0d errors", test_name, errors - test_errors);
        end
    endtask

    // Small signed samples keep every sum far from overflow
    task automatic fill_random_data();
        for (int w = 0; w < in_depth; w++) begin
            in_ref[w] = int'($urandom_range(15, 0)) - 8;
        end
        for (int w = 0; w < wt_depth; w++) begin
            wt_ref[w] = int'($urandom_range(15, 0)) - 8;
        end
    endtask

    task automatic compute_reference();
        int sum;
        for (int n = 0; n < tn; n++) begin
            for (int r = 0; r < orow; r++) begin
                for (int c = 0; c < ocol; c++) begin
                    sum = 0;
                    for (int m = 0; m < tm; m++) begin
                        for (int i = 0; i < k; i++) begin
                            for (int j = 0; j < k; j++) begin
                                sum += in_ref[m * tr * tc + (r + i) * tc + c + j]
                                     * wt_ref[(n * tm + m) * k * k + i * k + j];
                            end
                        end
                    end
                    out_ref[n * orow * ocol + r * ocol + c] = sum;
                end
            end
        end
    endtask

    task automatic load_buffers();
        logic err;
        for (int w = 0; w < in_depth; w++) begin
            write_word(win_addr(win_in, w), apb_dw'(in_ref[w]), err);
        end
        for (int w = 0; w < wt_depth; w++) begin
            write_word(win_addr(win_wt, w), apb_dw'(wt_ref[w]), err);
        end
    endtask

    task automatic verify_buffers();
        logic [apb_dw-1:0] rd;
        logic              err;
        for (int w = 0; w < in_depth; w++) begin
            read_word(win_addr(win_in, w), rd, err);
            expect_equal($sformatf("in[%0d]", w), in_ref[w], rd);
        end
        for (int w = 0; w < wt_depth; w++) begin
            read_word(win_addr(win_wt, w), rd, err);
            expect_equal($sformatf("wt[%0d]", w), wt_ref[w], rd);
        end
    endtask

    task automatic verify_outputs();
        logic [apb_dw-1:0] rd;
        logic              err;
        for (int w = 0; w < out_depth; w++) begin
            read_word(win_addr(win_out, w), rd, err);
            expect_equal($sformatf("out[%0d]", w), out_ref[w], rd);
        end
    endtask

    task automatic wait_for_done();
        logic [apb_dw-1:0] rd;
        logic              err;
        int                polls;
        polls = 0;
        rd    = '0;
        while (!rd[1] && polls < 2 * ops) begin
            read_word(reg_status, rd, err);
            polls++;
        end
        if (!rd[1]) begin
            errors++;
            $display("Error in %s: done flag not set after %0d status polls", test_name, polls);
        end
        host_idle = 1'b1;
    endtask

    initial begin
        logic [apb_dw-1:0] rd;
        logic              err;
        int                probe_w;
        seed_init    = $urandom(13);
        errors       = 0;
        checks       = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name    = "reset";
        host_idle    = 1'b1;
        probe_w      = 5;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        rst          = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        begin_test("reset");
        read_word(reg_status, rd, err);
        expect_equal("status", 0, rd);
        expect_equal("status pslverr", 0, err);
        read_word(reg_ctrl, rd, err);
        expect_equal("ctrl", 0, rd);
        end_test();

        begin_test("buffer_rw");
        fill_random_data();
        load_buffers();
        verify_buffers();
        end_test();
        compute_reference();

        begin_test("busy_access");
        write_word(reg_ctrl, 32'h1, err);
        host_idle = 1'b0;
        expect_equal("start pslverr", 0, err);
        read_word(reg_status, rd, err);
        expect_equal("busy status", 1, rd);
        expect_equal("status pslverr", 0, err);
        write_word(reg_ctrl, 32'h1, err);
        expect_equal("restart pslverr", 1, err);
        write_word(win_addr(win_in, probe_w), apb_dw'(in_ref[probe_w] + 1), err);
        expect_equal("window write pslverr", 1, err);
        read_word(win_addr(win_out, 0), rd, err);
        expect_equal("output read pslverr", 1, err);
        end_test();

        begin_test("first_run");
        wait_for_done();
        read_word(reg_status, rd, err);
        expect_equal("done status", 2, rd);
        verify_outputs();
        // The write attempted while busy must not have landed
        read_word(win_addr(win_in, probe_w), rd, err);
        expect_equal("probed input", in_ref[probe_w], rd);
        end_test();

        begin_test("second_run");
        fill_random_data();
        load_buffers();
        compute_reference();
        write_word(reg_ctrl, 32'h1, err);
        host_idle = 1'b0;
        read_word(reg_status, rd, err);
        expect_equal("done cleared", 1, rd);
        wait_for_done();
        read_word(reg_status, rd, err);
        expect_equal("done status", 2, rd);
        verify_outputs();
        end_test();

        $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Twice the budget of two runs plus all host traffic
    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles during %s", watchdog_cycles, test_name);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* conv_tile_top.sv */
// Host loads buffers over APB, starts, polls done and reads back; the engine owns the buffers while busy
`timescale 1ns/1ps

module conv_tile_top import conv_pkg::*; #(
    parameter int k  = def_k,
    parameter int tr = def_tr,
    parameter int tc = def_tc,
    parameter int tm = def_tm,
    parameter int tn = def_tn
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [apb_aw-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [apb_dw-1:0] pwdata,
    output logic [apb_dw-1:0] prdata,
    output logic              pready,
    output logic              pslverr
);

    localparam int in_depth  = tm * tr * tc;
    localparam int wt_depth  = tn * tm * k * k;
    localparam int out_depth = tn * (tr - k + 1) * (tc - k + 1);
    localparam int in_aw     = cnt_w(in_depth);
    localparam int wt_aw     = cnt_w(wt_depth);
    localparam int out_aw    = cnt_w(out_depth);

    logic              busy;
    logic              done;
    logic              start;
    logic [in_aw-1:0]  ctrl_in_addr;
    logic [wt_aw-1:0]  ctrl_wt_addr;
    logic [out_aw-1:0] ctrl_out_raddr;
    logic [out_aw-1:0] ctrl_out_waddr;
    logic              ctrl_out_we;
    logic              op_valid;
    logic              win_last;
    logic              first_slice;
    logic [data_w-1:0] in_rdata;
    logic [data_w-1:0] wt_rdata;
    logic [acc_w-1:0]  out_rdata;
    logic [acc_w-1:0]  out_wr_data;
    logic              host_in_we;
    logic [in_aw-1:0]  host_in_waddr;
    logic [data_w-1:0] host_in_wdata;
    logic [in_aw-1:0]  host_in_raddr;
    logic              host_wt_we;
    logic [wt_aw-1:0]  host_wt_waddr;
    logic [data_w-1:0] host_wt_wdata;
    logic [wt_aw-1:0]  host_wt_raddr;
    logic              host_out_we;
    logic [out_aw-1:0] host_out_waddr;
    logic [acc_w-1:0]  host_out_wdata;
    logic [out_aw-1:0] host_out_raddr;

    conv_apb_regs #(.in_aw(in_aw), .wt_aw(wt_aw), .out_aw(out_aw)) u_regs (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .busy(busy), .done(done), .start(start),
        .in_rdata(in_rdata), .wt_rdata(wt_rdata), .out_rdata(out_rdata),
        .host_in_we(host_in_we), .host_in_waddr(host_in_waddr),
        .host_in_wdata(host_in_wdata), .host_in_raddr(host_in_raddr),
        .host_wt_we(host_wt_we), .host_wt_waddr(host_wt_waddr),
        .host_wt_wdata(host_wt_wdata), .host_wt_raddr(host_wt_raddr),
        .host_out_we(host_out_we), .host_out_waddr(host_out_waddr),
        .host_out_wdata(host_out_wdata), .host_out_raddr(host_out_raddr)
    );

    // Input and weight buffers are written by the host only
    tile_buffer #(.depth(in_depth), .width(data_w)) u_in_buf (
        .clk(clk), .we(host_in_we), .waddr(host_in_waddr), .wdata(host_in_wdata),
        .raddr(busy ? ctrl_in_addr : host_in_raddr), .rdata(in_rdata)
    );
    tile_buffer #(.depth(wt_depth), .width(data_w)) u_wt_buf (
        .clk(clk), .we(host_wt_we), .waddr(host_wt_waddr), .wdata(host_wt_wdata),
        .raddr(busy ? ctrl_wt_addr : host_wt_raddr), .rdata(wt_rdata)
    );
    tile_buffer #(.depth(out_depth), .width(acc_w)) u_out_buf (
        .clk(clk), .we(busy ? ctrl_out_we : host_out_we),
        .waddr(busy ? ctrl_out_waddr : host_out_waddr),
        .wdata(busy ? out_wr_data : host_out_wdata),
        .raddr(busy ? ctrl_out_raddr : host_out_raddr), .rdata(out_rdata)
    );

    conv_ctrl_path #(.k(k), .tr(tr), .tc(tc), .tm(tm), .tn(tn)) u_ctrl (
        .clk(clk), .rst(rst), .start(start), .busy(busy), .done(done),
        .in_rd_addr(ctrl_in_addr), .wt_rd_addr(ctrl_wt_addr),
        .out_rd_addr(ctrl_out_raddr), .out_wr_addr(ctrl_out_waddr),
        .out_wr_en(ctrl_out_we), .op_valid(op_valid), .win_last(win_last),
        .first_slice(first_slice)
    );

    conv_mac_unit u_mac (
        .clk(clk), .rst(rst), .op_valid(op_valid), .win_last(win_last),
        .first_slice(first_slice), .in_data(in_rdata), .wt_data(wt_rdata),
        .psum(out_rdata), .out_wr_data(out_wr_data)
    );

endmodule

/* conv_apb_regs.sv */
// Zero wait states; buffer windows belong to the host only while the engine is idle
`timescale 1ns/1ps

module conv_apb_regs import conv_pkg::*; #(
    parameter int in_aw  = 7,
    parameter int wt_aw  = 6,
    parameter int out_aw = 5
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [apb_aw-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [apb_dw-1:0] pwdata,
    output logic [apb_dw-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              busy,
    input  logic              done,
    output logic              start,
    input  logic [data_w-1:0] in_rdata,
    input  logic [data_w-1:0] wt_rdata,
    input  logic [acc_w-1:0]  out_rdata,
    output logic              host_in_we,
    output logic [in_aw-1:0]  host_in_waddr,
    output logic [data_w-1:0] host_in_wdata,
    output logic [in_aw-1:0]  host_in_raddr,
    output logic              host_wt_we,
    output logic [wt_aw-1:0]  host_wt_waddr,
    output logic [data_w-1:0] host_wt_wdata,
    output logic [wt_aw-1:0]  host_wt_raddr,
    output logic              host_out_we,
    output logic [out_aw-1:0] host_out_waddr,
    output logic [acc_w-1:0]  host_out_wdata,
    output logic [out_aw-1:0] host_out_raddr
);

    logic       access;
    logic       wr;
    logic       ctrl_start;
    logic       sel_in;
    logic       sel_wt;
    logic       sel_out;
    logic [7:0] idx;
    logic       done_flag;

    assign access     = psel && penable;
    assign wr         = access && pwrite;
    assign ctrl_start = wr && (paddr == reg_ctrl) && pwdata[0];
    assign sel_in     = (paddr[9:8] == win_in[9:8]);
    assign sel_wt     = (paddr[9:8] == win_wt[9:8]);
    assign sel_out    = (paddr[9:8] == win_out[9:8]);
    // Bits 11:10 page the window beyond its first 64 words
    assign idx        = {paddr[11:10], paddr[7:2]};

    assign pready  = 1'b1;
    assign start   = ctrl_start && !busy;
    assign pslverr = busy && (ctrl_start || (access && (sel_in || sel_wt || sel_out)));

    assign host_in_we     = wr && sel_in && !busy;
    assign host_in_waddr  = in_aw'(idx);
    assign host_in_wdata  = pwdata[data_w-1:0];
    assign host_in_raddr  = in_aw'(idx);
    assign host_wt_we     = wr && sel_wt && !busy;
    assign host_wt_waddr  = wt_aw'(idx);
    assign host_wt_wdata  = pwdata[data_w-1:0];
    assign host_wt_raddr  = wt_aw'(idx);
    assign host_out_we    = wr && sel_out && !busy;
    assign host_out_waddr = out_aw'(idx);
    assign host_out_wdata = pwdata[acc_w-1:0];
    assign host_out_raddr = out_aw'(idx);

    // Window data was addressed in the setup phase and is valid now
    always_comb begin
        prdata = '0;
        if (paddr == reg_status) begin
            prdata[1:0] = {done_flag, busy};
        end else if (!busy && sel_in) begin
            prdata = {{(apb_dw - data_w){in_rdata[data_w-1]}}, in_rdata};
        end else if (!busy && sel_wt) begin
            prdata = {{(apb_dw - data_w){wt_rdata[data_w-1]}}, wt_rdata};
        end else if (!busy && sel_out) begin
            prdata = out_rdata;
        end
    end

    // Sticky until the next accepted start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_flag <= 1'b0;
        end else if (start) begin
            done_flag <= 1'b0;
        end else if (done) begin
            done_flag <= 1'b1;
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (rst) penable |-> psel)
        else $error("conv_apb_regs: penable without psel");

endmodule

/* conv_mac_unit.sv */
// Operands arrive one cycle after issue; the write-back value is ready four cycles after a window ends
`timescale 1ns/1ps

module conv_mac_unit import conv_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     op_valid,
    input  logic                     win_last,
    input  logic                     first_slice,
    input  logic signed [data_w-1:0] in_data,
    input  logic signed [data_w-1:0] wt_data,
    input  logic signed [acc_w-1:0]  psum,
    output logic signed [acc_w-1:0]  out_wr_data
);

    logic signed [acc_w-1:0] prod;
    logic signed [acc_w-1:0] acc;
    logic                    prod_vld;
    logic                    prod_last;
    logic                    prod_first;
    logic                    acc_open;
    logic                    acc_first;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prod_vld   <= 1'b0;
            prod_last  <= 1'b0;
            prod_first <= 1'b0;
            acc_open   <= 1'b0;
            acc_first  <= 1'b0;
        end else begin
            prod_vld   <= op_valid;
            prod_last  <= win_last;
            prod_first <= first_slice;
            acc_first  <= prod_first;
            // Next product starts a fresh window after the last one
            if (prod_vld) begin
                acc_open <= !prod_last;
            end
        end
    end

    always_ff @(posedge clk) begin
        prod <= in_data * wt_data;
        if (prod_vld) begin
            acc <= (acc_open ? acc : '0) + prod;
        end
        // The stored partial sum is stale on the first slice
        out_wr_data <= acc + (acc_first ? '0 : psum);
    end

    a_last_valid: assert property (@(posedge clk) disable iff (rst) win_last |-> op_valid)
        else $error("conv_mac_unit: window end without an operand");

endmodule

/* conv_ctrl_path.sv */
// One product per cycle with no stalls; start must arrive while idle, outputs lag issue by fixed delays
`timescale 1ns/1ps

module conv_ctrl_path import conv_pkg::*; #(
    parameter int k  = def_k,
    parameter int tr = def_tr,
    parameter int tc = def_tc,
    parameter int tm = def_tm,
    parameter int tn = def_tn
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          start,
    output logic                                          busy,
    output logic                                          done,
    output logic [cnt_w(tm*tr*tc)-1:0]                    in_rd_addr,
    output logic [cnt_w(tn*tm*k*k)-1:0]                   wt_rd_addr,
    output logic [cnt_w(tn*(tr-k+1)*(tc-k+1))-1:0]        out_rd_addr,
    output logic [cnt_w(tn*(tr-k+1)*(tc-k+1))-1:0]        out_wr_addr,
    output logic                                          out_wr_en,
    output logic                                          op_valid,
    output logic                                          win_last,
    output logic                                          first_slice
);

    localparam int orow   = tr - k + 1;
    localparam int ocol   = tc - k + 1;
    localparam int in_aw  = cnt_w(tm * tr * tc);
    localparam int wt_aw  = cnt_w(tn * tm * k * k);
    localparam int out_aw = cnt_w(tn * orow * ocol);

    logic                     running;
    logic [cnt_w(k)-1:0]      j;
    logic [cnt_w(k)-1:0]      i;
    logic [cnt_w(ocol)-1:0]   col;
    logic [cnt_w(orow)-1:0]   row;
    logic [cnt_w(tm)-1:0]     slice;
    logic [cnt_w(tn)-1:0]     blk;
    logic                     j_done;
    logic                     i_done;
    logic                     col_done;
    logic                     row_done;
    logic                     slice_done;
    logic                     blk_done;
    logic [out_aw-1:0]        out_addr;
    logic [2:0]               strobe_d;

    // Loop nest, innermost first: j, i, col, row, slice, block
    conv_counter #(.max_count(k)) u_cnt_j (
        .clk(clk), .rst(rst), .ena(running), .clear(start), .cnt(j), .done(j_done)
    );
    conv_counter #(.max_count(k)) u_cnt_i (
        .clk(clk), .rst(rst), .ena(j_done), .clear(start), .cnt(i), .done(i_done)
    );
    conv_counter #(.max_count(ocol)) u_cnt_col (
        .clk(clk), .rst(rst), .ena(i_done), .clear(start), .cnt(col), .done(col_done)
    );
    conv_counter #(.max_count(orow)) u_cnt_row (
        .clk(clk), .rst(rst), .ena(col_done), .clear(start), .cnt(row), .done(row_done)
    );
    conv_counter #(.max_count(tm)) u_cnt_slice (
        .clk(clk), .rst(rst), .ena(row_done), .clear(start), .cnt(slice), .done(slice_done)
    );
    conv_counter #(.max_count(tn)) u_cnt_blk (
        .clk(clk), .rst(rst), .ena(slice_done), .clear(start), .cnt(blk), .done(blk_done)
    );

    // Issue runs until the last op; busy also covers the write-back drain
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            busy    <= 1'b0;
        end else begin
            if (start) begin
                running <= 1'b1;
            end else if (blk_done) begin
                running <= 1'b0;
            end
            if (start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    assign in_rd_addr = in_aw'(slice * (tr * tc) + (row + i) * tc + col + j);
    assign wt_rd_addr = wt_aw'((blk * tm + slice) * (k * k) + i * k + j);
    assign out_addr   = out_aw'(blk * (orow * ocol) + row * ocol + col);

    // Strobes meet the buffer data one cycle after issue
    delay_line #(.depth(1), .payload_t(logic [2:0])) u_dly_strobe (
        .clk(clk), .rst(rst), .din({running, i_done, slice == 0}), .dout(strobe_d)
    );
    assign op_valid    = strobe_d[2];
    assign win_last    = strobe_d[1];
    assign first_slice = strobe_d[0];

    // Partial sum read at +2, write-back at +4 from the window's last element
    delay_line #(.depth(2), .payload_t(logic [out_aw-1:0])) u_dly_rd_addr (
        .clk(clk), .rst(rst), .din(out_addr), .dout(out_rd_addr)
    );
    delay_line #(.depth(2), .payload_t(logic [out_aw-1:0])) u_dly_wr_addr (
        .clk(clk), .rst(rst), .din(out_rd_addr), .dout(out_wr_addr)
    );
    delay_line #(.depth(4), .payload_t(logic)) u_dly_wr_en (
        .clk(clk), .rst(rst), .din(i_done), .dout(out_wr_en)
    );

    // Done follows the final write-back by one cycle
    delay_line #(.depth(5), .payload_t(logic)) u_dly_done (
        .clk(clk), .rst(rst), .din(blk_done), .dout(done)
    );

    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("conv_ctrl_path: start while busy");

    // The drain keeps busy high until the last write has gone out
    a_wr_busy: assert property (@(posedge clk) disable iff (rst) out_wr_en |-> busy)
        else $error("conv_ctrl_path: write-back outside a run");

endmodule

/* tile_buffer.sv */
// Read data is registered, so it appears the cycle after raddr; contents are undefined after power-up
`timescale 1ns/1ps

module tile_buffer import conv_pkg::*; #(
    parameter int depth = 64,
    parameter int width = 16
) (
    input  logic                    clk,
    input  logic                    we,
    input  logic [cnt_w(depth)-1:0] waddr,
    input  logic [width-1:0]        wdata,
    input  logic [cnt_w(depth)-1:0] raddr,
    output logic [width-1:0]        rdata
);

    logic [width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

    // A host paging past the buffer end would alias into other words
    a_waddr_range: assert property (@(posedge clk) we |-> waddr < depth)
        else $error("tile_buffer: write address %0d beyond depth %0d", waddr, depth);

endmodule

/* delay_line.sv */
// Fixed latency of depth cycles (depth >= 1); payload_t must be a packed type
`timescale 1ns/1ps

module delay_line #(
    parameter int  depth     = 1,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t din,
    output payload_t dout
);

    payload_t stages [depth];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < depth; s++) begin
                stages[s] <= '0;
            end
        end else begin
            stages[0] <= din;
            for (int s = 1; s < depth; s++) begin
                stages[s] <= stages[s - 1];
            end
        end
    end

    // Oldest stage
    assign dout = stages[depth - 1];

endmodule

/* conv_counter.sv */
// Counts enabled cycles from zero and wraps at max_count-1; clear has priority over ena
`timescale 1ns/1ps

module conv_counter import conv_pkg::*; #(
    parameter int max_count = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ena,
    input  logic                        clear,
    output logic [cnt_w(max_count)-1:0] cnt,
    output logic                        done
);

    // Pulses on the enabled cycle that holds the last count
    assign done = ena && (cnt == max_count - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (clear || done) begin
            cnt <= '0;
        end else if (ena) begin
            cnt <= cnt + 1'b1;
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (rst) cnt <= max_count - 1)
        else $error("conv_counter: count %0d beyond %0d", cnt, max_count - 1);

endmodule

/* conv_pkg.sv */
// Full-word APB; window word w lives at base + 0x400*(w/64) + 4*(w%64), stride fixed at 1
package conv_pkg;

    // Sample and partial-sum widths
    localparam int data_w = 16;
    localparam int acc_w  = 32;

    // Default tile geometry
    localparam int def_k  = 3;
    localparam int def_tr = 6;
    localparam int def_tc = 6;
    localparam int def_tm = 2;
    localparam int def_tn = 2;

    localparam int apb_aw = 12;
    localparam int apb_dw = 32;

    // Register map, byte offsets
    localparam logic [apb_aw-1:0] reg_ctrl   = 12'h000;
    localparam logic [apb_aw-1:0] reg_status = 12'h004;
    localparam logic [apb_aw-1:0] win_in     = 12'h100;
    localparam logic [apb_aw-1:0] win_wt     = 12'h200;
    localparam logic [apb_aw-1:0] win_out    = 12'h300;

    // Bits needed to count n states, never less than one
    function automatic int cnt_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage
